// ==== src/lsu_pkg.sv ====
package lsu_pkg;

    // data and address width
    localparam int xlen = 32;

    // memory opcode from the execute stage
    typedef enum logic [3:0] {
        NONE,
        LB,
        LBU,
        LH,
        LHU,
        LW,
        SB,
        SH,
        SW,
        LR_W,
        SC_W,
        AMO
    } mem_op_e;

    // amo operation, only looked at with AMO
    typedef enum logic [3:0] {
        SWAP,
        ADD,
        XOR,
        AND,
        OR,
        MIN,
        MAX,
        MINU,
        MAXU
    } amo_op_e;

    // atomic sequencer states
    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        STORE
    } amo_state_e;

    // decoded access
    typedef struct packed {
        logic       is_load;
        logic       is_store;
        logic       is_lr;
        logic       is_sc;
        logic       is_amo;
        // one-hot byte count, bit 0/1/2 = 1/2/4 bytes
        logic [3:0] size_onehot;
        logic       is_signed;
    } mem_op_info_t;

    // request from the atomic engine
    typedef struct packed {
        logic            active;
        logic            write;
        logic [xlen-1:0] wdata;
    } amo_req_t;

    // dcache port, valid is a level
    typedef struct packed {
        logic [xlen-1:0] addr;
        logic            valid;
        logic            write;
        logic [3:0]      mask;
        logic [3:0]      size;
        logic [xlen-1:0] wdata;
    } dcache_req_t;

    // clint port, answered in the same cycle
    typedef struct packed {
        logic [xlen-1:0] addr;
        logic            valid;
        logic            write;
        logic [xlen-1:0] wdata;
    } clint_req_t;

endpackage

// ==== src/mem_op_decode.sv ====
`timescale 1ns/100ps

module mem_op_decode (
    input  lsu_pkg::mem_op_e      mem_op_i,
    output lsu_pkg::mem_op_info_t info_o
);
    import lsu_pkg::*;

    always_comb begin
        info_o = '0;

        // access class
        // plain load and store flags stay low for atomics
        case (mem_op_i)
            LB, LBU, LH, LHU, LW: begin
                info_o.is_load = 1'b1;
            end
            SB, SH, SW: begin
                info_o.is_store = 1'b1;
            end
            LR_W: begin
                info_o.is_lr = 1'b1;
            end
            SC_W: begin
                info_o.is_sc = 1'b1;
            end
            AMO: begin
                info_o.is_amo = 1'b1;
            end
            default: begin
                info_o.is_load = 1'b0;
            end
        endcase

        // access size, atomics are always a word
        case (mem_op_i)
            LB, LBU, SB:             info_o.size_onehot = 4'b0001;
            LH, LHU, SH:             info_o.size_onehot = 4'b0010;
            LW, SW, LR_W, SC_W, AMO: info_o.size_onehot = 4'b0100;
            default:                 info_o.size_onehot = 4'b0000;
        endcase

        // sign extension only matters for sub-word loads
        info_o.is_signed = (mem_op_i == LB) || (mem_op_i == LH);
    end

endmodule

// ==== src/amo_alu.sv ====
`timescale 1ns/100ps

module amo_alu (
    input  lsu_pkg::amo_op_e         amo_op_i,
    input  logic [lsu_pkg::xlen-1:0] old_i,
    input  logic [lsu_pkg::xlen-1:0] rs2_i,
    output logic [lsu_pkg::xlen-1:0] new_o
);
    import lsu_pkg::*;

    logic lt_signed;
    logic lt_unsigned;

    // one compare each way, shared by min and max
    assign lt_signed   = $signed(old_i) < $signed(rs2_i);
    assign lt_unsigned = old_i < rs2_i;

    always_comb begin
        case (amo_op_i)
            SWAP:    new_o = rs2_i;
            ADD:     new_o = old_i + rs2_i;
            XOR:     new_o = old_i ^ rs2_i;
            AND:     new_o = old_i & rs2_i;
            OR:      new_o = old_i | rs2_i;
            MIN:     new_o = lt_signed ? old_i : rs2_i;
            MAX:     new_o = lt_signed ? rs2_i : old_i;
            MINU:    new_o = lt_unsigned ? old_i : rs2_i;
            MAXU:    new_o = lt_unsigned ? rs2_i : old_i;
            // unknown op behaves as swap
            default: new_o = rs2_i;
        endcase
    end

endmodule

// ==== src/amo_unit.sv ====
`timescale 1ns/100ps

module amo_unit (
    input  logic                     clk,
    input  logic                     rst,
    input  lsu_pkg::mem_op_info_t    info_i,
    input  lsu_pkg::amo_op_e         amo_op_i,
    input  logic                     amo_valid_i,
    input  logic [lsu_pkg::xlen-1:0] addr_i,
    input  logic [lsu_pkg::xlen-1:0] rs2_data_i,
    input  logic                     dcache_ready_i,
    input  logic [lsu_pkg::xlen-1:0] dcache_rdata_i,
    output lsu_pkg::amo_req_t        amo_req_o,
    output logic [lsu_pkg::xlen-1:0] amo_result_o,
    output logic                     amo_done_o,
    output logic                     misaligned_o
);
    import lsu_pkg::*;

    amo_state_e      state_q;
    logic            done_q;
    logic            res_valid_q;
    logic [xlen-1:0] res_addr_q;
    logic [xlen-1:0] loaded_q;
    logic [xlen-1:0] result_q;
    logic [xlen-1:0] alu_new;
    logic            is_atomic;
    logic            start;
    logic            sc_success;
    logic            sc_fail_start;

    assign is_atomic    = info_i.is_lr | info_i.is_sc | info_i.is_amo;
    assign misaligned_o = is_atomic & (addr_i[1:0] != 2'b00);
    // done_q blocks a restart while amo_valid_i is still up
    assign start         = amo_valid_i & is_atomic & ~misaligned_o & ~done_q;
    assign sc_success    = res_valid_q & (res_addr_q == addr_i);
    assign sc_fail_start = (state_q == IDLE) & start & info_i.is_sc & ~sc_success;

    amo_alu u_amo_alu (
        .amo_op_i (amo_op_i),
        .old_i    (loaded_q),
        .rs2_i    (rs2_data_i),
        .new_o    (alu_new)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q     <= IDLE;
            done_q      <= 1'b0;
            res_valid_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    // failed sc finishes here with no cache access
                    if (sc_fail_start) begin
                        done_q      <= 1'b1;
                        res_valid_q <= 1'b0;
                    end else if (start) begin
                        state_q <= info_i.is_sc ? STORE : LOAD;
                    end
                end
                LOAD: begin
                    if (dcache_ready_i) begin
                        if (info_i.is_lr) begin
                            state_q     <= IDLE;
                            done_q      <= 1'b1;
                            res_valid_q <= 1'b1;
                        end else begin
                            state_q <= STORE;
                        end
                    end
                end
                STORE: begin
                    // sc and amo both drop the reservation
                    if (dcache_ready_i) begin
                        state_q     <= IDLE;
                        done_q      <= 1'b1;
                        res_valid_q <= 1'b0;
                    end
                end
                default: state_q <= IDLE;
            endcase
            // plain store to the cache kills the reservation
            if (info_i.is_store && dcache_ready_i) begin
                res_valid_q <= 1'b0;
            end
        end
    end

    // data side of the sequencer
    always_ff @(posedge clk) begin
        if (state_q == LOAD && dcache_ready_i) begin
            loaded_q <= dcache_rdata_i;
            if (info_i.is_lr) begin
                result_q   <= dcache_rdata_i;
                res_addr_q <= addr_i;
            end
        end
        if (state_q == STORE && dcache_ready_i) begin
            // sc success returns 0, amo returns the old word
            result_q <= info_i.is_sc ? '0 : loaded_q;
        end
        if (sc_fail_start) begin
            result_q <= xlen'(1);
        end
    end

    // request only in LOAD and STORE
    assign amo_req_o.active = (state_q == LOAD) || (state_q == STORE);
    assign amo_req_o.write  = (state_q == STORE);
    assign amo_req_o.wdata  = info_i.is_sc ? rs2_data_i : alu_new;

    assign amo_result_o = result_q;
    assign amo_done_o   = done_q;

endmodule

// ==== src/mem_request.sv ====
`timescale 1ns/100ps

module mem_request #(
    parameter logic [lsu_pkg::xlen-1:0] clint_mtime_addr    = 32'h0200_BFF8,
    parameter logic [lsu_pkg::xlen-1:0] clint_mtimecmp_addr = 32'h0200_4000
) (
    input  lsu_pkg::mem_op_info_t    info_i,
    input  logic [lsu_pkg::xlen-1:0] addr_i,
    input  logic [lsu_pkg::xlen-1:0] rs2_data_i,
    input  lsu_pkg::amo_req_t        amo_req_i,
    input  logic                     dcache_ready_i,
    output lsu_pkg::dcache_req_t     dcache_req_o,
    output lsu_pkg::clint_req_t      clint_req_o,
    output logic                     clint_hit_o
);
    import lsu_pkg::*;

    logic            plain;
    logic            timer_addr;
    logic            clint_hit;
    logic            plain_cache;
    logic            pending;
    logic            write;
    logic [1:0]      offset;
    logic [3:0]      size_mask;
    logic [xlen-1:0] lane_wdata;

    assign plain = info_i.is_load | info_i.is_store;

    // low and high word of mtime and mtimecmp
    assign timer_addr = (addr_i == clint_mtime_addr)
                      | (addr_i == clint_mtime_addr + xlen'(4))
                      | (addr_i == clint_mtimecmp_addr)
                      | (addr_i == clint_mtimecmp_addr + xlen'(4));

    // atomics never go to the timer
    assign clint_hit   = plain & timer_addr;
    assign clint_hit_o = clint_hit;

    assign clint_req_o.addr  = addr_i;
    assign clint_req_o.valid = clint_hit;
    assign clint_req_o.write = clint_hit & info_i.is_store;
    assign clint_req_o.wdata = rs2_data_i;

    assign plain_cache = plain & ~clint_hit;
    // level request, drops in the ready cycle
    assign pending = plain_cache | amo_req_i.active;
    assign write   = amo_req_i.active ? amo_req_i.write : (plain_cache & info_i.is_store);

    // byte count to a low-aligned mask
    assign offset    = addr_i[1:0];
    assign size_mask = {info_i.size_onehot[2],
                        info_i.size_onehot[2],
                        info_i.size_onehot[2] | info_i.size_onehot[1],
                        |info_i.size_onehot[2:0]};
    // store data moved up to its byte lanes
    assign lane_wdata = rs2_data_i << {offset, 3'b000};

    always_comb begin
        dcache_req_o.addr  = addr_i;
        dcache_req_o.valid = pending & ~dcache_ready_i;
        dcache_req_o.write = write;
        dcache_req_o.size  = info_i.size_onehot;
        if (amo_req_i.active) begin
            // atomic is aligned, whole word
            dcache_req_o.mask  = 4'b1111;
            dcache_req_o.wdata = amo_req_i.wdata;
        end else begin
            // read mask stays unshifted
            dcache_req_o.mask  = write ? (size_mask << offset) : size_mask;
            dcache_req_o.wdata = lane_wdata;
        end
    end

endmodule

// ==== src/load_result.sv ====
`timescale 1ns/100ps

module load_result (
    input  lsu_pkg::mem_op_info_t    info_i,
    input  logic [lsu_pkg::xlen-1:0] addr_i,
    input  logic [lsu_pkg::xlen-1:0] dcache_rdata_i,
    input  logic [lsu_pkg::xlen-1:0] clint_rdata_i,
    input  logic                     clint_hit_i,
    input  logic [lsu_pkg::xlen-1:0] amo_result_i,
    output logic [lsu_pkg::xlen-1:0] result_o
);
    import lsu_pkg::*;

    logic [xlen-1:0] raw;
    logic            sign_b;
    logic            sign_h;

    // cache already returns the bytes in the low lanes
    assign raw    = clint_hit_i ? clint_rdata_i : dcache_rdata_i;
    assign sign_b = info_i.is_signed & raw[7];
    assign sign_h = info_i.is_signed & raw[15];

    always_comb begin
        if (info_i.is_lr || info_i.is_sc || info_i.is_amo) begin
            result_o = amo_result_i;
        end else if (info_i.is_load) begin
            case (info_i.size_onehot)
                4'b0001: result_o = {{24{sign_b}}, raw[7:0]};
                4'b0010: result_o = {{16{sign_h}}, raw[15:0]};
                default: result_o = raw;
            endcase
        end else begin
            // none or store, alu value passes on
            result_o = addr_i;
        end
    end

endmodule

// ==== src/lsu_top.sv ====
`timescale 1ns/100ps

module lsu_top #(
    parameter logic [lsu_pkg::xlen-1:0] clint_mtime_addr    = 32'h0200_BFF8,
    parameter logic [lsu_pkg::xlen-1:0] clint_mtimecmp_addr = 32'h0200_4000
) (
    input  logic                     clk,
    input  logic                     rst,
    input  lsu_pkg::mem_op_e         mem_op_i,
    input  lsu_pkg::amo_op_e         amo_op_i,
    input  logic                     amo_valid_i,
    input  logic [lsu_pkg::xlen-1:0] addr_i,
    input  logic [lsu_pkg::xlen-1:0] rs2_data_i,
    output lsu_pkg::dcache_req_t     dcache_req_o,
    input  logic                     dcache_ready_i,
    input  logic [lsu_pkg::xlen-1:0] dcache_rdata_i,
    output lsu_pkg::clint_req_t      clint_req_o,
    input  logic [lsu_pkg::xlen-1:0] clint_rdata_i,
    output logic [lsu_pkg::xlen-1:0] result_o,
    output logic                     amo_done_o,
    output logic                     amo_misaligned_o,
    output logic                     stall_o
);
    import lsu_pkg::*;

    mem_op_info_t    info;
    amo_req_t        amo_req;
    logic [xlen-1:0] amo_result;
    logic            clint_hit;

    mem_op_decode u_decode (
        .mem_op_i (mem_op_i),
        .info_o   (info)
    );

    amo_unit u_amo (
        .clk            (clk),
        .rst            (rst),
        .info_i         (info),
        .amo_op_i       (amo_op_i),
        .amo_valid_i    (amo_valid_i),
        .addr_i         (addr_i),
        .rs2_data_i     (rs2_data_i),
        .dcache_ready_i (dcache_ready_i),
        .dcache_rdata_i (dcache_rdata_i),
        .amo_req_o      (amo_req),
        .amo_result_o   (amo_result),
        .amo_done_o     (amo_done_o),
        .misaligned_o   (amo_misaligned_o)
    );

    mem_request #(
        .clint_mtime_addr    (clint_mtime_addr),
        .clint_mtimecmp_addr (clint_mtimecmp_addr)
    ) u_request (
        .info_i         (info),
        .addr_i         (addr_i),
        .rs2_data_i     (rs2_data_i),
        .amo_req_i      (amo_req),
        .dcache_ready_i (dcache_ready_i),
        .dcache_req_o   (dcache_req_o),
        .clint_req_o    (clint_req_o),
        .clint_hit_o    (clint_hit)
    );

    load_result u_result (
        .info_i         (info),
        .addr_i         (addr_i),
        .dcache_rdata_i (dcache_rdata_i),
        .clint_rdata_i  (clint_rdata_i),
        .clint_hit_i    (clint_hit),
        .amo_result_i   (amo_result),
        .result_o       (result_o)
    );

    // hold the pipe on a pending cache access or a running atomic
    // a misaligned atomic lets the trap through
    assign stall_o = dcache_req_o.valid
                   | (amo_valid_i & ~amo_done_o & ~amo_misaligned_o);

endmodule

// ==== verif/lsu_checker.sv ====
`timescale 1ns/100ps

module lsu_checker (
    input logic                 clk,
    input logic                 rst,
    input lsu_pkg::dcache_req_t dcache_req_i,
    input lsu_pkg::clint_req_t  clint_req_i,
    input logic                 amo_done_i
);

    // one target per access
    a_one_target: assert property (@(posedge clk) disable iff (rst)
        !(dcache_req_i.valid && clint_req_i.valid))
        else $error("cache and clint requests valid in the same cycle");

    // done never lasts two cycles
    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        amo_done_i |=> !amo_done_i)
        else $error("amo_done_o high for more than one cycle");

    // a write always carries byte enables
    a_write_mask: assert property (@(posedge clk) disable iff (rst)
        (dcache_req_i.valid && dcache_req_i.write) |-> (dcache_req_i.mask != 4'b0000))
        else $error("cache write with an empty mask");

    a_done_reset: assert property (@(posedge clk)
        rst |-> !amo_done_i)
        else $error("amo_done_o high during reset");

endmodule

bind lsu_top lsu_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .dcache_req_i (dcache_req_o),
    .clint_req_i  (clint_req_o),
    .amo_done_i   (amo_done_o)
);

// ==== verif/tb_lsu.sv ====
`timescale 1ns/100ps

module tb_lsu;
    import lsu_pkg::*;

    localparam logic [31:0] mtime_addr    = 32'h0200_BFF8;
    localparam logic [31:0] mtimecmp_addr = 32'h0200_4000;
    // tests take about 300 cycles, limit leaves a wide margin
    localparam int max_cycles = 3000;

    logic        clk = 1'b0;
    logic        rst;
    mem_op_e     mem_op;
    amo_op_e     amo_op;
    logic        amo_valid;
    logic [31:0] addr;
    logic [31:0] rs2;
    dcache_req_t dcache_req;
    logic        dcache_ready = 1'b0;
    logic [31:0] dcache_rdata = 32'h0;
    clint_req_t  clint_req;
    logic [31:0] clint_rdata;
    logic [31:0] result;
    logic        amo_done;
    logic        amo_misaligned;
    logic        stall;

    // cache model state and the expected memory image
    logic [31:0] cache_mem [16];
    logic [31:0] golden [16];
    dcache_req_t seen_req;
    int          wait_cnt = 0;
    int          cycles = 0;
    int          errors = 0;
    int          checks = 0;

    lsu_top #(
        .clint_mtime_addr    (mtime_addr),
        .clint_mtimecmp_addr (mtimecmp_addr)
    ) DUT (
        .clk              (clk),
        .rst              (rst),
        .mem_op_i         (mem_op),
        .amo_op_i         (amo_op),
        .amo_valid_i      (amo_valid),
        .addr_i           (addr),
        .rs2_data_i       (rs2),
        .dcache_req_o     (dcache_req),
        .dcache_ready_i   (dcache_ready),
        .dcache_rdata_i   (dcache_rdata),
        .clint_req_o      (clint_req),
        .clint_rdata_i    (clint_rdata),
        .result_o         (result),
        .amo_done_o       (amo_done),
        .amo_misaligned_o (amo_misaligned),
        .stall_o          (stall)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    // clint answers in the same cycle, one pattern per timer word
    function automatic logic [31:0] clint_pattern(input logic [31:0] a);
        return {16'hc1a7, a[15:0]};
    endfunction

    assign clint_rdata = clint_req.valid ? clint_pattern(clint_req.addr) : 32'h0;

    // applies one cache access, read data lands in the low lanes
    task automatic cache_access(input dcache_req_t req);
        logic [3:0] idx;
        idx = req.addr[5:2];
        if (req.write) begin
            for (int i = 0; i < 4; i++) begin
                if (req.mask[i]) begin
                    cache_mem[idx][8*i +: 8] = req.wdata[8*i +: 8];
                end
            end
        end
        dcache_rdata = cache_mem[idx] >> {req.addr[1:0], 3'b000};
    endtask

    // request sampled mid cycle
    always @(negedge clk) seen_req = dcache_req;

    // ready pulse two cycles after valid is seen
    always @(posedge clk) begin
        #2;
        if (rst) begin
            dcache_ready = 1'b0;
            wait_cnt = 0;
            for (int i = 0; i < 16; i++) begin
                cache_mem[i] = golden[i];
            end
        end else if (dcache_ready) begin
            dcache_ready = 1'b0;
        end else if (seen_req.valid) begin
            wait_cnt = wait_cnt + 1;
            if (wait_cnt == 2) begin
                wait_cnt = 0;
                cache_access(seen_req);
                dcache_ready = 1'b1;
            end
        end else begin
            wait_cnt = 0;
        end
    end

    task automatic check(input logic [31:0] expected, input logic [31:0] actual,
                         input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t: %s, expected %h, got %h", $time, what, expected, actual);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic drive_idle();
        mem_op = NONE;
        amo_op = SWAP;
        amo_valid = 1'b0;
        addr = 32'h0;
        rs2 = 32'h0;
    endtask

    // load value as the isa defines it
    function automatic logic [31:0] load_expect(input mem_op_e op, input logic [31:0] word,
                                                input logic [1:0] off);
        logic [31:0] lanes;
        lanes = word >> {off, 3'b000};
        case (op)
            LB:      return {{24{lanes[7]}}, lanes[7:0]};
            LBU:     return {24'h0, lanes[7:0]};
            LH:      return {{16{lanes[15]}}, lanes[15:0]};
            LHU:     return {16'h0, lanes[15:0]};
            default: return lanes;
        endcase
    endfunction

    // one-hot byte count of a plain access, 1/2/4 bytes
    function automatic logic [3:0] access_size(input mem_op_e op);
        case (op)
            LB, LBU, SB: return 4'b0001;
            LH, LHU, SH: return 4'b0010;
            default:     return 4'b0100;
        endcase
    endfunction

    function automatic logic [31:0] amo_expect(input amo_op_e op, input logic [31:0] old_v,
                                               input logic [31:0] src);
        case (op)
            ADD:     return old_v + src;
            XOR:     return old_v ^ src;
            AND:     return old_v & src;
            OR:      return old_v | src;
            MIN:     return ($signed(old_v) < $signed(src)) ? old_v : src;
            MAX:     return ($signed(old_v) > $signed(src)) ? old_v : src;
            MINU:    return (old_v < src) ? old_v : src;
            MAXU:    return (old_v > src) ? old_v : src;
            default: return src;
        endcase
    endfunction

    task automatic plain_load(input mem_op_e op, input logic [31:0] a,
                              input logic [31:0] expected);
        mem_op = op;
        addr = a;
        @(negedge clk);
        check(32'd1, 32'(dcache_req.valid & ~dcache_req.write), "load request");
        check(32'(access_size(op)), 32'(dcache_req.size), "load size");
        check(32'd1, 32'(stall), "stall while load pending");
        while (!dcache_ready) @(negedge clk);
        check(expected, result, "load result");
        check(32'd0, 32'(stall), "stall in load ready cycle");
        next_cycle();
        mem_op = NONE;
    endtask

    task automatic plain_store(input mem_op_e op, input logic [31:0] a,
                               input logic [31:0] data);
        logic [3:0]  mask;
        logic [1:0]  off;
        logic [3:0]  idx;
        logic [31:0] shifted;
        off = a[1:0];
        idx = a[5:2];
        shifted = data << {off, 3'b000};
        case (op)
            SB:      mask = 4'b0001 << off;
            SH:      mask = 4'b0011 << off;
            default: mask = 4'b1111;
        endcase
        mem_op = op;
        addr = a;
        rs2 = data;
        @(negedge clk);
        check(32'd1, 32'(dcache_req.valid & dcache_req.write), "store request");
        check(32'(access_size(op)), 32'(dcache_req.size), "store size");
        check(32'(mask), 32'(dcache_req.mask), "store mask");
        check(shifted, dcache_req.wdata, "store lane data");
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) begin
                golden[idx][8*i +: 8] = shifted[8*i +: 8];
            end
        end
        while (!dcache_ready) @(negedge clk);
        check(32'd0, 32'(stall), "stall in store ready cycle");
        next_cycle();
        mem_op = NONE;
    endtask

    // runs one atomic to its done pulse, counts cycles with a cache request
    task automatic run_atomic(input mem_op_e op, input amo_op_e aop, input logic [31:0] a,
                              input logic [31:0] data, output logic [31:0] res,
                              output int req_cycles);
        req_cycles = 0;
        mem_op = op;
        amo_op = aop;
        addr = a;
        rs2 = data;
        amo_valid = 1'b1;
        @(negedge clk);
        while (!amo_done) begin
            if (dcache_req.valid) req_cycles++;
            check(32'd1, 32'(stall), "stall while atomic runs");
            @(negedge clk);
        end
        res = result;
        check(32'd0, 32'(stall), "stall in done cycle");
        next_cycle();
        amo_valid = 1'b0;
        mem_op = NONE;
    endtask

    task automatic test_reset_idle();
        @(negedge clk);
        check(32'd0, 32'(amo_done), "done after reset");
        check(32'd0, 32'(stall), "stall after reset");
        check(32'd0, 32'(dcache_req.valid), "cache valid after reset");
        check(32'd0, 32'(clint_req.valid), "clint valid after reset");
    endtask

    task automatic test_loads();
        logic [31:0] a;
        for (int off = 0; off < 4; off++) begin
            // one word per offset
            a = 32'((4 + off) * 4 + off);
            plain_load(LB, a, load_expect(LB, golden[4 + off], 2'(off)));
            plain_load(LBU, a, load_expect(LBU, golden[4 + off], 2'(off)));
            if (off % 2 == 0) begin
                plain_load(LH, a, load_expect(LH, golden[4 + off], 2'(off)));
                plain_load(LHU, a, load_expect(LHU, golden[4 + off], 2'(off)));
            end
            if (off == 0) begin
                plain_load(LW, a, load_expect(LW, golden[4], 2'(off)));
            end
        end
    endtask

    task automatic test_stores();
        for (int off = 0; off < 4; off++) begin
            plain_store(SB, 32'(32 + off), $urandom);
        end
        plain_store(SH, 32'd36, $urandom);
        plain_store(SH, 32'd38, $urandom);
        plain_store(SW, 32'd40, $urandom);
        // merged words read back
        plain_load(LW, 32'd32, golden[8]);
        plain_load(LW, 32'd36, golden[9]);
        plain_load(LW, 32'd40, golden[10]);
    endtask

    task automatic test_clint();
        logic [31:0] timer [4];
        timer[0] = mtime_addr;
        timer[1] = mtime_addr + 32'd4;
        timer[2] = mtimecmp_addr;
        timer[3] = mtimecmp_addr + 32'd4;
        for (int i = 0; i < 4; i++) begin
            mem_op = LW;
            addr = timer[i];
            @(negedge clk);
            check(32'd1, 32'(clint_req.valid & ~clint_req.write), "clint read request");
            check(32'd0, 32'(dcache_req.valid), "cache idle on clint read");
            check(32'd0, 32'(stall), "stall on clint read");
            check(clint_pattern(timer[i]), result, "clint read data");
            next_cycle();
            mem_op = SW;
            rs2 = $urandom;
            @(negedge clk);
            check(32'd1, 32'(clint_req.valid & clint_req.write), "clint write request");
            check(rs2, clint_req.wdata, "clint write data");
            check(32'd0, 32'(dcache_req.valid), "cache idle on clint write");
            check(32'd0, 32'(stall), "stall on clint write");
            next_cycle();
        end
        drive_idle();
    endtask

    task automatic test_amo();
        logic [31:0] res;
        logic [31:0] data;
        logic [31:0] old_v;
        int          n;
        for (int k = 0; k < 9; k++) begin
            data = $urandom;
            old_v = golden[12];
            run_atomic(AMO, amo_op_e'(k), 32'd48, data, res, n);
            check(old_v, res, "amo returns old word");
            golden[12] = amo_expect(amo_op_e'(k), old_v, data);
            check(golden[12], cache_mem[12], "amo memory word");
        end
    endtask

    task automatic test_reservation();
        logic [31:0] res;
        logic [31:0] data;
        int          n;
        run_atomic(LR_W, SWAP, 32'd52, 32'h0, res, n);
        check(golden[13], res, "lr result");
        data = $urandom;
        run_atomic(SC_W, SWAP, 32'd52, data, res, n);
        check(32'd0, res, "sc after lr");
        check(32'd1, 32'(n != 0), "sc after lr writes");
        golden[13] = data;
        check(golden[13], cache_mem[13], "sc after lr memory");
        // reservation was used up by the sc
        run_atomic(SC_W, SWAP, 32'd52, $urandom, res, n);
        check(32'd1, res, "sc without reservation");
        check(32'd0, 32'(n), "sc without reservation request cycles");
        check(golden[13], cache_mem[13], "sc without reservation memory");
        // plain store between lr and sc
        run_atomic(LR_W, SWAP, 32'd52, 32'h0, res, n);
        plain_store(SW, 32'd52, $urandom);
        run_atomic(SC_W, SWAP, 32'd52, $urandom, res, n);
        check(32'd1, res, "sc after plain store");
        check(32'd0, 32'(n), "sc after plain store request cycles");
        check(golden[13], cache_mem[13], "sc after plain store memory");
        // misaligned amo traps and never starts
        mem_op = AMO;
        amo_op = ADD;
        addr = 32'd54;
        rs2 = $urandom;
        amo_valid = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check(32'd1, 32'(amo_misaligned), "misaligned flag");
            check(32'd0, 32'(dcache_req.valid), "misaligned request");
            check(32'd0, 32'(stall), "misaligned stall");
            check(32'd0, 32'(amo_done), "misaligned done");
        end
        next_cycle();
        drive_idle();
    endtask

    initial begin
        void'($urandom(32'h6c25));
        rst = 1'b1;
        drive_idle();
        for (int i = 0; i < 16; i++) begin
            golden[i] = $urandom;
        end
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        test_reset_idle();
        next_cycle();
        test_loads();
        test_stores();
        test_clint();
        test_amo();
        test_reservation();
        repeat (2) next_cycle();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
src/lsu_pkg.sv
src/mem_op_decode.sv
src/amo_alu.sv
src/amo_unit.sv
src/mem_request.sv
src/load_result.sv
src/lsu_top.sv
verif/lsu_checker.sv
verif/tb_lsu.sv

// ==== run.sh ====
#!/bin/sh
# build and run the lsu testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_lsu -f list.f

output=$(./obj_dir/Vtb_lsu)
echo "$output"

if echo "$output" | grep -q "^Testbench passed$"; then
    exit 0
else
    exit 1
fi
